// File: hw/pixel_pkg.sv
// screen geometry of the 160x120 framebuffer
// coordinate and colour field widths
`default_nettype none

package pixel_pkg;

	// visible area
	localparam int screen_w = 160;
	localparam int screen_h = 120;

	// x needs 8 bits for 0..159, y needs 7 bits for 0..119
	localparam int x_w = 8;
	localparam int y_w = 7;

	// rgb 4-4-4
	localparam int color_w = 12;

endpackage

`default_nettype wire

// File: hw/scene_pkg.sv
// scene layout constants: sprite count, tile size, horizon
// background colours, item palette and tile corner rule
`default_nettype none

package scene_pkg;

	import pixel_pkg::*;

	// stone, gold, diamond
	localparam int num_sprites = 3;
	localparam int tile_size = 8;

	// rows above this one are sky
	localparam int horizon_row = 40;

	localparam logic [color_w-1:0] sky_color = 12'h6bf;
	localparam logic [color_w-1:0] ground_color = 12'h742;

	// entry 0 is stone (grey), 1 is gold (yellow), 2 is diamond (cyan)
	localparam logic [num_sprites-1:0][color_w-1:0] sprite_palette = {
		12'h0ee,
		12'hfd1,
		12'h999
	};

	// tile pixels near the top left and bottom right diagonal ends are cut
	localparam int corner_cut = 2;

endpackage

`default_nettype wire

// File: hw/scene_sequencer.sv
// frame control FSM
// runs the background painter, then each sprite painter in turn
`timescale 1ns/1ps
`default_nettype none

module scene_sequencer
	import scene_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   go,
	input  wire logic                   bg_done,
	input  wire logic [num_sprites-1:0] spr_done,
	output logic                        bg_start,
	output logic      [num_sprites-1:0] spr_start,
	output logic                        busy,
	output logic                        frame_done
);

	localparam int idx_w = (num_sprites > 1) ? $clog2(num_sprites) : 1;
	localparam logic [idx_w-1:0] last_idx = idx_w'(num_sprites - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_bg,
		st_spr,
		st_fin
	} state_t;

	state_t state;
	logic [idx_w-1:0] spr_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			spr_idx <= '0;
			bg_start <= 1'b0;
			spr_start <= '0;
		end else begin
			// start strobes last a single cycle
			bg_start <= 1'b0;
			spr_start <= '0;

			case (state)
				st_idle: begin
					if (go) begin
						bg_start <= 1'b1;
						state <= st_bg;
					end
				end

				st_bg: begin
					if (bg_done) begin
						spr_idx <= '0;
						spr_start <= num_sprites'(1);
						state <= st_spr;
					end
				end

				st_spr: begin
					if (spr_done[spr_idx]) begin
						if (spr_idx == last_idx) begin
							state <= st_fin;
						end else begin
							// next item sprite
							spr_idx <= spr_idx + 1'b1;
							spr_start <= num_sprites'(1) << (spr_idx + 1'b1);
						end
					end
				end

				// one cycle, lines up with the merge output of the last pixel
				st_fin: state <= st_idle;

				default: state <= st_idle;
			endcase
		end
	end

	// busy covers bg_start through frame_done, so go is ignored all along
	assign busy = (state != st_idle);
	assign frame_done = (state == st_fin);

endmodule

`default_nettype wire

// File: hw/background_painter.sv
// background painter
// scans every screen position once, sky above the horizon, ground below
`timescale 1ns/1ps
`default_nettype none

module background_painter
	import pixel_pkg::*;
	import scene_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               start,
	output logic                    valid,
	output logic      [x_w-1:0]     x,
	output logic      [y_w-1:0]     y,
	output logic      [color_w-1:0] color,
	output logic                    done
);

	localparam logic [x_w-1:0] last_x = x_w'(screen_w - 1);
	localparam logic [y_w-1:0] last_y = y_w'(screen_h - 1);

	logic running;

	// raster scan, x fastest
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			x <= '0;
			y <= '0;
		end else if (start) begin
			running <= 1'b1;
			x <= '0;
			y <= '0;
		end else if (running) begin
			if (x == last_x) begin
				x <= '0;
				if (y == last_y) begin
					running <= 1'b0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	assign valid = running;
	assign color = (y < y_w'(horizon_row)) ? sky_color : ground_color;

	// bottom right corner is the final pixel
	assign done = running && (x == last_x) && (y == last_y);

endmodule

`default_nettype wire

// File: hw/sprite_painter.sv
// sprite painter for one 8x8 item tile
// cut corners and off-screen positions are marked not opaque
`timescale 1ns/1ps
`default_nettype none

module sprite_painter
	import pixel_pkg::*;
	import scene_pkg::*;
#(
	parameter logic [color_w-1:0] sprite_color = 12'hfff
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               start,
	input  wire logic [x_w-1:0]     x_init,
	input  wire logic [y_w-1:0]     y_init,
	output logic                    valid,
	output logic      [x_w-1:0]     x,
	output logic      [y_w-1:0]     y,
	output logic      [color_w-1:0] color,
	output logic                    opaque,
	output logic                    done
);

	localparam int uv_w = $clog2(tile_size);
	localparam int diag_w = uv_w + 1;
	localparam logic [uv_w-1:0] last_uv = uv_w'(tile_size - 1);
	// largest u+v that is still drawn
	localparam int diag_hi = 2 * tile_size - 2 - corner_cut;

	logic running;
	logic [uv_w-1:0] u;
	logic [uv_w-1:0] v;
	logic [x_w-1:0] org_x;
	logic [y_w-1:0] org_y;
	logic [x_w:0] sum_x;
	logic [y_w:0] sum_y;
	logic [diag_w-1:0] diag;
	logic cut;
	logic on_screen;

	// origin is sampled once per frame
	always_ff @(posedge clk) begin
		if (start) begin
			org_x <= x_init;
			org_y <= y_init;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			u <= '0;
			v <= '0;
		end else if (start) begin
			running <= 1'b1;
			u <= '0;
			v <= '0;
		end else if (running) begin
			u <= u + 1'b1;
			if (u == last_uv) begin
				if (v == last_uv) begin
					running <= 1'b0;
				end else begin
					v <= v + 1'b1;
				end
			end
		end
	end

	// one extra bit so a tile past the right or bottom edge does not wrap
	assign sum_x = {1'b0, org_x} + {{(x_w + 1 - uv_w){1'b0}}, u};
	assign sum_y = {1'b0, org_y} + {{(y_w + 1 - uv_w){1'b0}}, v};
	assign on_screen = (sum_x < (x_w + 1)'(screen_w)) && (sum_y < (y_w + 1)'(screen_h));

	assign diag = {1'b0, u} + {1'b0, v};
	assign cut = (diag < diag_w'(corner_cut)) || (diag > diag_w'(diag_hi));

	assign valid = running;
	assign x = sum_x[x_w-1:0];
	assign y = sum_y[y_w-1:0];
	assign color = sprite_color;
	assign opaque = on_screen && !cut;
	assign done = running && (u == last_uv) && (v == last_uv);

endmodule

`default_nettype wire

// File: hw/pixel_merge.sv
// pixel merge
// picks the single active drawer and registers the framebuffer write
`timescale 1ns/1ps
`default_nettype none

module pixel_merge
	import pixel_pkg::*;
#(
	parameter int num_src = 4
) (
	input  wire logic                            clk,
	input  wire logic                            rst,
	input  wire logic [num_src-1:0]              src_valid,
	input  wire logic [num_src-1:0][x_w-1:0]     src_x,
	input  wire logic [num_src-1:0][y_w-1:0]     src_y,
	input  wire logic [num_src-1:0][color_w-1:0] src_color,
	input  wire logic [num_src-1:0]              src_opaque,
	output logic                                 fb_we,
	output logic      [x_w-1:0]                  fb_x,
	output logic      [y_w-1:0]                  fb_y,
	output logic      [color_w-1:0]              fb_color
);

	logic [x_w-1:0] sel_x;
	logic [y_w-1:0] sel_y;
	logic [color_w-1:0] sel_color;
	logic sel_we;

	// at most one source is valid, so an OR of the masked fields selects it
	always_comb begin
		sel_x = '0;
		sel_y = '0;
		sel_color = '0;
		for (int i = 0; i < num_src; i++) begin
			if (src_valid[i]) begin
				sel_x = sel_x | src_x[i];
				sel_y = sel_y | src_y[i];
				sel_color = sel_color | src_color[i];
			end
		end
	end

	// transparent and clipped pixels are dropped here
	assign sel_we = |(src_valid & src_opaque);

	always_ff @(posedge clk) begin
		if (rst) begin
			fb_we <= 1'b0;
		end else begin
			fb_we <= sel_we;
		end
	end

	always_ff @(posedge clk) begin
		fb_x <= sel_x;
		fb_y <= sel_y;
		fb_color <= sel_color;
	end

endmodule

`default_nettype wire

// File: hw/scene_view.sv
// scene renderer top level
// sequencer, background painter, item sprite painters and the pixel merge
`timescale 1ns/1ps
`default_nettype none

module scene_view
	import pixel_pkg::*;
	import scene_pkg::*;
(
	input  wire logic                              clk,
	input  wire logic                              rst,
	input  wire logic                              go,
	input  wire logic [num_sprites-1:0][x_w-1:0]   sprite_x,
	input  wire logic [num_sprites-1:0][y_w-1:0]   sprite_y,
	output logic                                   fb_we,
	output logic      [x_w-1:0]                    fb_x,
	output logic      [y_w-1:0]                    fb_y,
	output logic      [color_w-1:0]                fb_color,
	output logic                                   busy,
	output logic                                   frame_done
);

	localparam int num_src = num_sprites + 1;

	logic bg_start;
	logic bg_done;
	logic bg_valid;
	logic [x_w-1:0] bg_x;
	logic [y_w-1:0] bg_y;
	logic [color_w-1:0] bg_color;

	logic [num_sprites-1:0] spr_start;
	logic [num_sprites-1:0] spr_done;
	logic [num_sprites-1:0] spr_valid;
	logic [num_sprites-1:0] spr_opaque;
	logic [num_sprites-1:0][x_w-1:0] spr_x;
	logic [num_sprites-1:0][y_w-1:0] spr_y;
	logic [num_sprites-1:0][color_w-1:0] spr_color;

	scene_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.go         (go),
		.bg_done    (bg_done),
		.spr_done   (spr_done),
		.bg_start   (bg_start),
		.spr_start  (spr_start),
		.busy       (busy),
		.frame_done (frame_done)
	);

	background_painter u_bg (
		.clk   (clk),
		.rst   (rst),
		.start (bg_start),
		.valid (bg_valid),
		.x     (bg_x),
		.y     (bg_y),
		.color (bg_color),
		.done  (bg_done)
	);

	// one painter per item, each with its own palette entry
	for (genvar i = 0; i < num_sprites; i++) begin : g_spr
		sprite_painter #(
			.sprite_color (sprite_palette[i])
		) u_spr (
			.clk    (clk),
			.rst    (rst),
			.start  (spr_start[i]),
			.x_init (sprite_x[i]),
			.y_init (sprite_y[i]),
			.valid  (spr_valid[i]),
			.x      (spr_x[i]),
			.y      (spr_y[i]),
			.color  (spr_color[i]),
			.opaque (spr_opaque[i]),
			.done   (spr_done[i])
		);
	end

	// source 0 is the background, which is always opaque
	pixel_merge #(
		.num_src (num_src)
	) u_merge (
		.clk        (clk),
		.rst        (rst),
		.src_valid  ({spr_valid, bg_valid}),
		.src_x      ({spr_x, bg_x}),
		.src_y      ({spr_y, bg_y}),
		.src_color  ({spr_color, bg_color}),
		.src_opaque ({spr_opaque, 1'b1}),
		.fb_we      (fb_we),
		.fb_x       (fb_x),
		.fb_y       (fb_y),
		.fb_color   (fb_color)
	);

endmodule

`default_nettype wire

// File: testbench/scene_view_asserts.sv
// concurrent protocol checks for the scene renderer
// start strobes, idle writes, frame_done shape, reset state
`timescale 1ns/1ps
`default_nettype none

module scene_view_asserts
	import scene_pkg::*;
(
	input wire logic                   clk,
	input wire logic                   rst,
	input wire logic                   bg_start,
	input wire logic [num_sprites-1:0] spr_start,
	input wire logic                   busy,
	input wire logic                   frame_done,
	input wire logic                   fb_we
);

	int fail_count = 0;

	// only one drawer may be started in a cycle
	a_start_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({spr_start, bg_start}))
	else begin
		$error("more than one drawer start strobe is high");
		fail_count++;
	end

	a_idle_no_write: assert property (@(posedge clk) disable iff (rst)
		!busy |-> !fb_we)
	else begin
		$error("framebuffer write while the sequencer is idle");
		fail_count++;
	end

	// single cycle strobe, and the sequencer is back in idle after it
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		frame_done |=> !frame_done && !busy)
	else begin
		$error("frame_done longer than one cycle or busy still high after it");
		fail_count++;
	end

	a_busy_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> bg_start)
	else begin
		$error("busy rose without a background start");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !busy && !frame_done && !fb_we && !bg_start && (spr_start == '0))
	else begin
		$error("outputs not cleared by reset");
		fail_count++;
	end

endmodule

bind scene_view scene_view_asserts u_asserts (
	.clk        (clk),
	.rst        (rst),
	.bg_start   (bg_start),
	.spr_start  (spr_start),
	.busy       (busy),
	.frame_done (frame_done),
	.fb_we      (fb_we)
);

`default_nettype wire

// File: testbench/tb_scene_view.sv
// testbench for the scene renderer
// expected write list per frame, frame stimulus and error counts
`timescale 1ns/1ps
`default_nettype none

module tb_scene_view
	import pixel_pkg::*;
	import scene_pkg::*;
();

	localparam int timeout_cycles = 25000;
	localparam int frame_cycles = screen_w * screen_h + num_sprites * tile_size * tile_size + 5;
	localparam int wr_w = x_w + y_w + color_w;

	logic clk;
	logic rst;
	logic go;
	logic [num_sprites-1:0][x_w-1:0] sprite_x;
	logic [num_sprites-1:0][y_w-1:0] sprite_y;
	logic fb_we;
	logic [x_w-1:0] fb_x;
	logic [y_w-1:0] fb_y;
	logic [color_w-1:0] fb_color;
	logic busy;
	logic frame_done;

	// expected writes of the running frame as {x, y, color} in write order
	logic [wr_w-1:0] exp_q[$];
	string test_name;
	int mismatch_count;
	int other_count;
	int frame_count;
	int write_count;
	int frame_expected;
	bit go_seen;
	bit timed_out;
	logic [31:0] lcg_state;

	scene_view dut (
		.clk        (clk),
		.rst        (rst),
		.go         (go),
		.sprite_x   (sprite_x),
		.sprite_y   (sprite_y),
		.fb_we      (fb_we),
		.fb_x       (fb_x),
		.fb_y       (fb_y),
		.fb_color   (fb_color),
		.busy       (busy),
		.frame_done (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// a tile position is written when on screen and outside both cut corners
	function automatic bit tile_pixel_drawn(input int px, input int py, input int u, input int v);
		int d;
		d = u + v;
		if (px + u >= screen_w || py + v >= screen_h)
			return 1'b0;
		return (d >= corner_cut) && (d <= 2 * tile_size - 2 - corner_cut);
	endfunction

	task automatic check_field(input string what, input int expected, input int actual,
			input bit as_hex);
		if (expected != actual) begin
			mismatch_count++;
			if (as_hex)
				$display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what,
					expected, actual);
			else
				$display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what,
					expected, actual);
		end
	endtask

	task automatic build_expected();
		int sx;
		int sy;
		logic [color_w-1:0] c;
		exp_q.delete();
		for (int y = 0; y < screen_h; y++) begin
			c = (y < horizon_row) ? sky_color : ground_color;
			for (int x = 0; x < screen_w; x++)
				exp_q.push_back({x_w'(x), y_w'(y), c});
		end
		for (int s = 0; s < num_sprites; s++) begin
			sx = int'(sprite_x[s]);
			sy = int'(sprite_y[s]);
			for (int v = 0; v < tile_size; v++)
				for (int u = 0; u < tile_size; u++)
					if (tile_pixel_drawn(sx, sy, u, v))
						exp_q.push_back({x_w'(sx + u), y_w'(sy + v), sprite_palette[s]});
		end
	endtask

	task automatic place_random();
		for (int s = 0; s < num_sprites; s++) begin
			lcg_state = lcg_next(lcg_state);
			sprite_x[s] = x_w'(lcg_state[31:16] % screen_w);
			lcg_state = lcg_next(lcg_state);
			sprite_y[s] = y_w'(lcg_state[31:16] % screen_h);
		end
	endtask

	task automatic end_run();
		int assert_fails;
		assert_fails = dut.u_asserts.fail_count;
		$display("errors: %0d mismatches, %0d other, %0d assertion failures",
			mismatch_count, other_count, assert_fails);
		if (mismatch_count + other_count + assert_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// one frame from go to frame_done and optionally a stray go while busy
	task automatic run_frame(input string name, input bit second_go);
		int cycles;
		int frames_before;
		// no further frames once one has hung
		if (timed_out)
			return;
		test_name = name;
		build_expected();
		frame_expected = exp_q.size();
		$display("%s: %0d sprite writes expected", name, frame_expected - screen_w * screen_h);
		frames_before = frame_count;
		@(posedge clk);
		#1;
		go = 1'b1;
		go_seen = 1'b1;
		cycles = 0;
		while (!frame_done && cycles < timeout_cycles) begin
			@(posedge clk);
			#1;
			cycles++;
			go = second_go && (cycles == 100);
		end
		if (!frame_done) begin
			$display("%s: timed out waiting for frame_done", name);
			other_count++;
			timed_out = 1'b1;
			return;
		end
		check_field("cycles from go to frame_done", frame_cycles, cycles, 1'b0);
		// a second frame would have raised busy again by now
		repeat (20) @(posedge clk);
		#1;
		if (busy || frame_count != frames_before + 1) begin
			$display("%s: expected exactly one frame per go, another one started", name);
			other_count++;
		end
	endtask

	// write monitor sampled mid cycle
	always @(negedge clk) begin
		logic [wr_w-1:0] e;
		if (!rst) begin
			if (!go_seen && (busy || frame_done || fb_we)) begin
				$display("busy, frame_done or fb_we went high before the first go");
				other_count++;
			end
			if (fb_we) begin
				write_count++;
				if (exp_q.size() == 0) begin
					$display("%s: write at x %0d y %0d when no write was expected",
						test_name, fb_x, fb_y);
					other_count++;
				end else begin
					e = exp_q.pop_front();
					check_field("fb_x", int'(e[wr_w-1 -: x_w]), int'(fb_x), 1'b0);
					check_field("fb_y", int'(e[color_w+y_w-1 -: y_w]), int'(fb_y), 1'b0);
					check_field("fb_color", int'(e[color_w-1:0]), int'(fb_color), 1'b1);
				end
			end
			if (frame_done) begin
				frame_count++;
				check_field("write count", frame_expected, write_count, 1'b0);
				write_count = 0;
			end
		end
	end

	initial begin
		rst = 1'b1;
		go = 1'b0;
		sprite_x = '0;
		sprite_y = '0;
		go_seen = 1'b0;
		timed_out = 1'b0;
		lcg_state = 32'h94f64cdb;
		mismatch_count = 0;
		other_count = 0;
		frame_count = 0;
		write_count = 0;
		frame_expected = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// quiet period before the first go
		repeat (10) @(posedge clk);
		#1;

		sprite_x[0] = x_w'(20);
		sprite_y[0] = y_w'(50);
		sprite_x[1] = x_w'(70);
		sprite_y[1] = y_w'(60);
		sprite_x[2] = x_w'(120);
		sprite_y[2] = y_w'(90);
		run_frame("visible", 1'b0);

		// right edge, bottom edge, and the bottom right corner
		sprite_x[0] = x_w'(156);
		sprite_y[0] = y_w'(10);
		sprite_x[1] = x_w'(30);
		sprite_y[1] = y_w'(117);
		sprite_x[2] = x_w'(156);
		sprite_y[2] = y_w'(117);
		run_frame("clip", 1'b0);

		place_random();
		run_frame("busy_go", 1'b1);

		for (int i = 0; i < 3; i++) begin
			place_random();
			run_frame($sformatf("random%0d", i), 1'b0);
		end
		end_run();
	end

endmodule

`default_nettype wire

// File: tb.f
hw/pixel_pkg.sv
hw/scene_pkg.sv
hw/scene_sequencer.sv
hw/background_painter.sv
hw/sprite_painter.sv
hw/pixel_merge.sv
hw/scene_view.sv
testbench/scene_view_asserts.sv
testbench/tb_scene_view.sv

// File: run_sim.sh
#!/bin/sh
# build and run the scene renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module tb_scene_view -f tb.f -o sim_scene_view
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_scene_view > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$log"; then
	exit 1
fi
exit 0
